// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	localparam int REGISTER_BITS = 4;

	typedef logic [15:0] word_t;                 // Instruction or data word
	typedef logic [REGISTER_BITS - 1:0] reg_idx_t;
	typedef logic [11:0] imm_hi_t;               // Payload of an IMM prefix

	localparam reg_idx_t R0 = '0;                // Also means "no register"

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_IMM  = 4'd1,
		OP_ALU  = 4'd2,
		OP_BR   = 4'd4,
		OP_HALT = 4'd15
	} opcode_t;

	localparam word_t NOP_INSTRUCTION = 16'h0000;

	// Reset / branch mask and stall mask length
	localparam int MASK_CYCLES = 2;

	// ALU field positions
	localparam int ALU_DST_LSB = 4;
	localparam int ALU_SRC_LSB = 0;

	function automatic opcode_t opcode_of(word_t w);
		return opcode_t'(w[15:12]);
	endfunction

	function automatic imm_hi_t imm_hi_of(word_t w);
		return w[11:0];
	endfunction

	function automatic logic [3:0] imm_lo_of(word_t w);
		return w[3:0];
	endfunction

endpackage

// ==== cpu_bus_pkg.sv ====
package cpu_bus_pkg;

	typedef logic [11:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Register map
	localparam apb_addr_t REG_CTRL    = 12'h000;    // Bit 0 run
	localparam apb_addr_t REG_STATUS  = 12'h004;    // Bit 0 halted, bit 1 running
	localparam apb_addr_t REG_RETIRED = 12'h008;    // Retired instruction count

	// Program word n lives at PROG_BASE + 4n
	localparam apb_addr_t PROG_BASE = 12'h400;

	localparam int CTRL_RUN_BIT      = 0;
	localparam int STATUS_HALTED_BIT = 0;
	localparam int STATUS_RUN_BIT    = 1;

endpackage

// ==== instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory #(
	parameter int ADDRESS_BITS = 8
) (
	input  logic CLK,
	input  logic we,
	input  logic [ADDRESS_BITS - 1:0] waddr,
	input  cpu_isa_pkg::word_t wdata,
	input  logic [ADDRESS_BITS - 1:0] raddr,
	output cpu_isa_pkg::word_t rdata
);

	cpu_isa_pkg::word_t mem [0:(1 << ADDRESS_BITS) - 1];

	always_ff @(posedge CLK) begin
		if (we)
			mem[waddr] <= wdata;   // Host load port
		rdata <= mem[raddr];       // Fetch port, one cycle latency
	end

endmodule

// ==== prog_apb_port.sv ====
`timescale 1ns/1ps

module prog_apb_port #(
	parameter int ADDRESS_BITS = 8
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  cpu_bus_pkg::apb_addr_t paddr,
	input  cpu_bus_pkg::apb_data_t pwdata,
	output cpu_bus_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic mem_we,
	output logic [ADDRESS_BITS - 1:0] mem_waddr,
	output cpu_isa_pkg::word_t mem_wdata,
	output logic run_req,
	input  logic halted,
	input  logic running,
	input  logic retire_valid
);

	logic access;
	logic is_ctrl, is_status, is_retired, in_prog, mapped;
	cpu_bus_pkg::apb_addr_t prog_offset;
	cpu_bus_pkg::apb_data_t retired_count;

	assign access      = psel && penable;   // APB access phase
	assign prog_offset = paddr - cpu_bus_pkg::PROG_BASE;

	assign is_ctrl    = (paddr == cpu_bus_pkg::REG_CTRL);
	assign is_status  = (paddr == cpu_bus_pkg::REG_STATUS);
	assign is_retired = (paddr == cpu_bus_pkg::REG_RETIRED);
	assign in_prog    = (paddr >= cpu_bus_pkg::PROG_BASE) && (prog_offset[1:0] == 2'b00) &&
		((prog_offset >> 2) < (1 << ADDRESS_BITS));
	assign mapped     = is_ctrl || is_status || is_retired || in_prog;

	assign pready  = 1'b1;                  // No wait states
	assign pslverr = access && (!mapped || (pwrite && in_prog && running));

	// Program words only go in while the core is stopped
	assign mem_we    = access && pwrite && in_prog && !running;
	assign mem_waddr = prog_offset[ADDRESS_BITS + 1:2];
	assign mem_wdata = pwdata[15:0];

	assign run_req = access && pwrite && is_ctrl && pwdata[cpu_bus_pkg::CTRL_RUN_BIT];

	always_ff @(posedge CLK) begin
		if (!RSTb)
			retired_count <= '0;
		else if (run_req)
			retired_count <= '0;   // New run starts a fresh count
		else if (retire_valid)
			retired_count <= retired_count + 1'b1;
	end

	always_comb begin
		prdata = '0;
		if (is_ctrl)
			prdata[cpu_bus_pkg::CTRL_RUN_BIT] = running;
		else if (is_status) begin
			prdata[cpu_bus_pkg::STATUS_HALTED_BIT] = halted;
			prdata[cpu_bus_pkg::STATUS_RUN_BIT]    = running;
		end else if (is_retired)
			prdata = retired_count;
	end

endmodule

// ==== fetch_sequencer.sv ====
`timescale 1ns/1ps

module fetch_sequencer #(
	parameter int ADDRESS_BITS = 8
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic run_req,
	input  logic stall,
	input  cpu_isa_pkg::word_t load_pc_target,
	input  cpu_isa_pkg::word_t pipeline_stage2,
	input  cpu_isa_pkg::word_t pipeline_stage4,
	output logic [ADDRESS_BITS - 1:0] fetch_addr,
	output logic [ADDRESS_BITS - 1:0] memory_address,
	output logic memory_is_instruction,
	output logic is_executing,
	output logic load_pc,
	output logic halted,
	output logic running
);

	typedef enum logic [1:0] {IDLE, RUN, HALTED} state_t;

	state_t state;
	logic [ADDRESS_BITS - 1:0] pc;
	logic issue;
	logic fetch_valid;   // fetch_addr holds a word on the program path
	logic halt_seen;

	assign is_executing = (state == RUN);
	assign running      = (state == RUN);
	assign halted       = (state == HALTED);

	// Branch resolves in stage 2
	assign load_pc   = (state == RUN) &&
		(cpu_isa_pkg::opcode_of(pipeline_stage2) == cpu_isa_pkg::OP_BR);
	assign halt_seen = (state == RUN) &&
		(cpu_isa_pkg::opcode_of(pipeline_stage4) == cpu_isa_pkg::OP_HALT);
	assign issue     = (state == RUN) && !stall && !load_pc;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= IDLE;
			pc <= '0;
			fetch_valid <= 1'b0;
			memory_is_instruction <= 1'b0;
		end else begin
			case (state)
				IDLE, HALTED: if (run_req) begin
					state <= RUN;
					pc <= '0;
				end
				RUN: if (halt_seen)
					state <= HALTED;
				else if (load_pc)
					pc <= ADDRESS_BITS'(load_pc_target);
				else if (!stall)
					pc <= pc + 1'b1;   // PC holds while stalled
				default: state <= IDLE;
			endcase
			fetch_valid <= issue;
			memory_is_instruction <= fetch_valid && !load_pc;   // Drop wrong-path words
		end
	end

	always_ff @(posedge CLK) begin
		fetch_addr <= pc;
		memory_address <= fetch_addr;   // PC of the word now on memory_in
	end

endmodule

// ==== stall_mask_timer.sv ====
`timescale 1ns/1ps

module stall_mask_timer (
	input  logic CLK,
	input  logic RSTb,
	input  logic is_executing,
	input  logic stall,
	input  logic load_pc,
	input  logic reading_alt,
	output logic mask_active,
	output logic stall_mask_active,
	output logic fifo_write,
	output logic [2:0] fifo_wptr,
	output logic [2:0] fifo_rptr
);

	logic [1:0] mask_count;
	logic [1:0] alt_load;   // Fetches in flight, bit 1 is on memory_in now
	logic issue;

	assign issue = is_executing && !stall && !load_pc;

	assign mask_active       = (mask_count != 2'd0);
	assign stall_mask_active = (fifo_wptr != fifo_rptr);   // Banked words pending replay

	// Bank a valid word when stage 0 cannot take it directly
	assign fifo_write = alt_load[1] && !load_pc && (stall || stall_mask_active);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			mask_count <= 2'(cpu_isa_pkg::MASK_CYCLES);
			alt_load <= 2'b00;
			fifo_wptr <= 3'd0;
			fifo_rptr <= 3'd0;
		end else begin
			if (load_pc || !is_executing)
				mask_count <= 2'(cpu_isa_pkg::MASK_CYCLES);
			else if (mask_count != 2'd0)
				mask_count <= mask_count - 1'b1;

			alt_load <= {alt_load[0] && !load_pc, issue};

			if (load_pc || !is_executing) begin
				fifo_wptr <= 3'd0;
				fifo_rptr <= 3'd0;
			end else begin
				if (fifo_write)
					fifo_wptr <= fifo_wptr + 1'b1;
				if (reading_alt)
					fifo_rptr <= fifo_rptr + 1'b1;
			end
		end
	end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  cpu_isa_pkg::word_t pipeline_stage0,
	input  cpu_isa_pkg::reg_idx_t hazard_reg1,
	input  cpu_isa_pkg::reg_idx_t hazard_reg2,
	input  cpu_isa_pkg::reg_idx_t hazard_reg3,
	input  logic modifies_flags1,
	input  logic modifies_flags2,
	input  logic modifies_flags3,
	output cpu_isa_pkg::reg_idx_t hazard_reg0,
	output logic modifies_flags0,
	output logic stall,
	output logic hazard1
);

	cpu_isa_pkg::reg_idx_t dst, src;
	cpu_isa_pkg::reg_idx_t haz [1:3];
	logic flg [1:3];
	logic is_alu, is_br;
	logic [3:1] match;

	assign is_alu = (cpu_isa_pkg::opcode_of(pipeline_stage0) == cpu_isa_pkg::OP_ALU);
	assign is_br  = (cpu_isa_pkg::opcode_of(pipeline_stage0) == cpu_isa_pkg::OP_BR);
	assign dst    = pipeline_stage0[cpu_isa_pkg::ALU_DST_LSB +: cpu_isa_pkg::REGISTER_BITS];
	assign src    = pipeline_stage0[cpu_isa_pkg::ALU_SRC_LSB +: cpu_isa_pkg::REGISTER_BITS];

	assign hazard_reg0     = is_alu ? dst : cpu_isa_pkg::R0;
	assign modifies_flags0 = is_alu;

	assign haz = '{hazard_reg1, hazard_reg2, hazard_reg3};
	assign flg = '{modifies_flags1, modifies_flags2, modifies_flags3};

	// ALU reads both its operands, a branch waits for pending flags
	always_comb begin
		for (int i = 1; i <= 3; i++)
			match[i] = (is_alu && haz[i] != cpu_isa_pkg::R0 && (haz[i] == dst || haz[i] == src)) ||
				(is_br && flg[i]);
	end

	assign stall   = |match;
	assign hazard1 = match[1] && !match[2] && !match[3];   // Only stage 1 blocks

endmodule

// ==== cpu_pipeline.sv ====
`timescale 1ns/1ps

module cpu_pipeline #(
	parameter int ADDRESS_BITS = 8
) (
	input  logic CLK,
	input  logic RSTb,
	input  cpu_isa_pkg::word_t memory_in,
	input  logic [ADDRESS_BITS - 1:0] memory_address,
	input  logic memory_is_instruction,
	input  logic is_executing,
	input  logic stall,
	input  logic hazard1,
	input  logic load_pc,
	input  logic mask_active,
	input  logic stall_mask_active,
	input  logic fifo_write,
	input  logic [2:0] fifo_wptr,
	input  logic [2:0] fifo_rptr,
	input  cpu_isa_pkg::reg_idx_t hazard_reg0,
	input  logic modifies_flags0,
	output cpu_isa_pkg::word_t pipeline_stage0,
	output cpu_isa_pkg::word_t pipeline_stage2,
	output cpu_isa_pkg::word_t pipeline_stage4,
	output logic [ADDRESS_BITS - 1:0] pc_stage4,
	output cpu_isa_pkg::word_t imm_reg,
	output cpu_isa_pkg::reg_idx_t hazard_reg1,
	output cpu_isa_pkg::reg_idx_t hazard_reg2,
	output cpu_isa_pkg::reg_idx_t hazard_reg3,
	output logic modifies_flags1,
	output logic modifies_flags2,
	output logic modifies_flags3,
	output logic reading_alt,
	output logic retire_valid,
	output cpu_isa_pkg::word_t retire_ins,
	output logic [ADDRESS_BITS - 1:0] retire_pc,
	output cpu_isa_pkg::word_t retire_imm
);

	cpu_isa_pkg::word_t stage_q [0:4], stage_d [0:4];
	logic [ADDRESS_BITS - 1:0] pc_q [0:4], pc_d [0:4];
	cpu_isa_pkg::word_t imm_q [2:4], imm_d [2:4];   // Immediate travelling with stages 2..4
	cpu_isa_pkg::reg_idx_t haz_q [1:3], haz_d [1:3];
	logic flg_q [1:3], flg_d [1:3];
	cpu_isa_pkg::imm_hi_t prefix_q, prefix_d, prefix_after_s1;
	cpu_isa_pkg::word_t imm_from_s1;

	cpu_isa_pkg::word_t instruction_fifo [0:7];
	logic [ADDRESS_BITS - 1:0] pc_fifo [0:7];

	assign pipeline_stage0 = stage_q[0];
	assign pipeline_stage2 = stage_q[2];
	assign pipeline_stage4 = stage_q[4];
	assign pc_stage4       = pc_q[4];
	assign imm_reg         = imm_q[2];
	assign hazard_reg1     = haz_q[1];
	assign hazard_reg2     = haz_q[2];
	assign hazard_reg3     = haz_q[3];
	assign modifies_flags1 = flg_q[1];
	assign modifies_flags2 = flg_q[2];
	assign modifies_flags3 = flg_q[3];

	// Immediate seen by the word leaving stage 1, and the prefix left behind
	assign imm_from_s1 = {prefix_q, cpu_isa_pkg::imm_lo_of(stage_q[1])};
	always_comb begin
		if (cpu_isa_pkg::opcode_of(stage_q[1]) == cpu_isa_pkg::OP_IMM)
			prefix_after_s1 = cpu_isa_pkg::imm_hi_of(stage_q[1]);
		else if (stage_q[1] == cpu_isa_pkg::NOP_INSTRUCTION)
			prefix_after_s1 = prefix_q;   // NOPs keep a pending prefix
		else
			prefix_after_s1 = '0;
	end

	always_comb begin
		stage_d = stage_q;
		pc_d = pc_q;
		imm_d = imm_q;
		haz_d = haz_q;
		flg_d = flg_q;
		prefix_d = prefix_q;
		reading_alt = 1'b0;

		if (!is_executing) begin
			stage_d = '{default: cpu_isa_pkg::NOP_INSTRUCTION};
			haz_d = '{default: cpu_isa_pkg::R0};
			flg_d = '{default: 1'b0};
			prefix_d = '0;
		end else if (load_pc) begin
			// Flush everything before execute
			stage_d[4] = stage_q[3];
			stage_d[3] = stage_q[2];
			stage_d[0] = cpu_isa_pkg::NOP_INSTRUCTION;
			stage_d[1] = cpu_isa_pkg::NOP_INSTRUCTION;
			stage_d[2] = cpu_isa_pkg::NOP_INSTRUCTION;
			pc_d[4] = pc_q[3];
			pc_d[3] = pc_q[2];
			imm_d[4] = imm_q[3];
			imm_d[3] = imm_q[2];
			haz_d = '{cpu_isa_pkg::R0, cpu_isa_pkg::R0, haz_q[2]};
			flg_d = '{1'b0, 1'b0, flg_q[2]};
			prefix_d = '0;
		end else begin
			stage_d[4] = stage_q[3];
			stage_d[3] = stage_q[2];
			pc_d[4] = pc_q[3];
			pc_d[3] = pc_q[2];
			imm_d[4] = imm_q[3];
			imm_d[3] = imm_q[2];
			haz_d[3] = haz_q[2];
			flg_d[3] = flg_q[2];
			if (stall && !hazard1) begin
				stage_d[2] = cpu_isa_pkg::NOP_INSTRUCTION;   // Bubble, stages 0 and 1 hold
				haz_d[2] = cpu_isa_pkg::R0;
				flg_d[2] = 1'b0;
			end else begin
				stage_d[2] = stage_q[1];
				pc_d[2] = pc_q[1];
				imm_d[2] = imm_from_s1;
				haz_d[2] = haz_q[1];
				flg_d[2] = flg_q[1];
				prefix_d = prefix_after_s1;
			end
			if (stall && hazard1) begin
				stage_d[1] = cpu_isa_pkg::NOP_INSTRUCTION;   // Stage 1 released
				haz_d[1] = cpu_isa_pkg::R0;
				flg_d[1] = 1'b0;
			end else if (!stall) begin
				stage_d[1] = stage_q[0];
				pc_d[1] = pc_q[0];
				haz_d[1] = hazard_reg0;
				flg_d[1] = modifies_flags0;
				if (stall_mask_active) begin
					reading_alt = 1'b1;   // Replay banked words first
					stage_d[0] = instruction_fifo[fifo_rptr];
					pc_d[0] = pc_fifo[fifo_rptr];
				end else if (memory_is_instruction && !mask_active) begin
					stage_d[0] = memory_in;
					pc_d[0] = memory_address;
				end else
					stage_d[0] = cpu_isa_pkg::NOP_INSTRUCTION;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage_q <= '{default: cpu_isa_pkg::NOP_INSTRUCTION};
			haz_q <= '{default: cpu_isa_pkg::R0};
			flg_q <= '{default: 1'b0};
			prefix_q <= '0;
			retire_valid <= 1'b0;
		end else begin
			stage_q <= stage_d;
			haz_q <= haz_d;
			flg_q <= flg_d;
			prefix_q <= prefix_d;
			retire_valid <= is_executing && (stage_q[4] != cpu_isa_pkg::NOP_INSTRUCTION);
		end
	end

	always_ff @(posedge CLK) begin
		pc_q <= pc_d;
		imm_q <= imm_d;
		retire_ins <= stage_q[4];
		retire_pc <= pc_q[4];
		retire_imm <= imm_q[4];
		if (fifo_write) begin
			instruction_fifo[fifo_wptr] <= memory_in;
			pc_fifo[fifo_wptr] <= memory_address;
		end
	end

endmodule

// ==== slurm16_frontend.sv ====
`timescale 1ns/1ps

module slurm16_frontend #(
	parameter int ADDRESS_BITS = 8
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  cpu_bus_pkg::apb_addr_t paddr,
	input  cpu_bus_pkg::apb_data_t pwdata,
	output cpu_bus_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic retire_valid,
	output cpu_isa_pkg::word_t retire_ins,
	output logic [ADDRESS_BITS - 1:0] retire_pc,
	output cpu_isa_pkg::word_t retire_imm
);

	logic mem_we, run_req, halted, running;
	logic [ADDRESS_BITS - 1:0] mem_waddr, fetch_addr, memory_address;
	cpu_isa_pkg::word_t mem_wdata, memory_in, imm_reg;
	cpu_isa_pkg::word_t pipeline_stage0, pipeline_stage2, pipeline_stage4;
	logic memory_is_instruction, is_executing, load_pc, stall, hazard1;
	logic mask_active, stall_mask_active, fifo_write, reading_alt;
	logic [2:0] fifo_wptr, fifo_rptr;
	cpu_isa_pkg::reg_idx_t hazard_reg0, hazard_reg1, hazard_reg2, hazard_reg3;
	logic modifies_flags0, modifies_flags1, modifies_flags2, modifies_flags3;

	instruction_memory #(.ADDRESS_BITS(ADDRESS_BITS)) u_instruction_memory (
		.CLK(CLK), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
		.raddr(fetch_addr), .rdata(memory_in)
	);

	prog_apb_port #(.ADDRESS_BITS(ADDRESS_BITS)) u_prog_apb_port (
		.CLK(CLK), .RSTb(RSTb), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .run_req(run_req),
		.halted(halted), .running(running), .retire_valid(retire_valid)
	);

	fetch_sequencer #(.ADDRESS_BITS(ADDRESS_BITS)) u_fetch_sequencer (
		.CLK(CLK), .RSTb(RSTb), .run_req(run_req), .stall(stall), .load_pc_target(imm_reg),
		.pipeline_stage2(pipeline_stage2), .pipeline_stage4(pipeline_stage4),
		.fetch_addr(fetch_addr), .memory_address(memory_address),
		.memory_is_instruction(memory_is_instruction), .is_executing(is_executing),
		.load_pc(load_pc), .halted(halted), .running(running)
	);

	stall_mask_timer u_stall_mask_timer (
		.CLK(CLK), .RSTb(RSTb), .is_executing(is_executing), .stall(stall), .load_pc(load_pc),
		.reading_alt(reading_alt), .mask_active(mask_active),
		.stall_mask_active(stall_mask_active), .fifo_write(fifo_write),
		.fifo_wptr(fifo_wptr), .fifo_rptr(fifo_rptr)
	);

	hazard_unit u_hazard_unit (
		.pipeline_stage0(pipeline_stage0), .hazard_reg1(hazard_reg1), .hazard_reg2(hazard_reg2),
		.hazard_reg3(hazard_reg3), .modifies_flags1(modifies_flags1),
		.modifies_flags2(modifies_flags2), .modifies_flags3(modifies_flags3),
		.hazard_reg0(hazard_reg0), .modifies_flags0(modifies_flags0), .stall(stall),
		.hazard1(hazard1)
	);

	cpu_pipeline #(.ADDRESS_BITS(ADDRESS_BITS)) u_cpu_pipeline (
		.CLK(CLK), .RSTb(RSTb), .memory_in(memory_in), .memory_address(memory_address),
		.memory_is_instruction(memory_is_instruction), .is_executing(is_executing),
		.stall(stall), .hazard1(hazard1), .load_pc(load_pc), .mask_active(mask_active),
		.stall_mask_active(stall_mask_active), .fifo_write(fifo_write),
		.fifo_wptr(fifo_wptr), .fifo_rptr(fifo_rptr), .hazard_reg0(hazard_reg0),
		.modifies_flags0(modifies_flags0), .pipeline_stage0(pipeline_stage0),
		.pipeline_stage2(pipeline_stage2), .pipeline_stage4(pipeline_stage4),
		.pc_stage4(), .imm_reg(imm_reg), .hazard_reg1(hazard_reg1),
		.hazard_reg2(hazard_reg2), .hazard_reg3(hazard_reg3),
		.modifies_flags1(modifies_flags1), .modifies_flags2(modifies_flags2),
		.modifies_flags3(modifies_flags3), .reading_alt(reading_alt),
		.retire_valid(retire_valid), .retire_ins(retire_ins), .retire_pc(retire_pc),
		.retire_imm(retire_imm)
	);

endmodule

// ==== tb_frontend.sv ====
`timescale 1ns/1ps

module tb_frontend;

	localparam int ADDRESS_BITS = 8;
	localparam int NUM_PROGS = 4;
	localparam int MAX_WORDS = 32;
	localparam int PAD_WORDS = 10;          // NOPs after each program cover fetches past HALT
	localparam int HAZARD_ALU_WORDS = 16;

	logic CLK = 1'b0;
	logic RSTb;
	logic psel, penable, pwrite;
	cpu_bus_pkg::apb_addr_t paddr;
	cpu_bus_pkg::apb_data_t pwdata, prdata;
	logic pready, pslverr;
	logic retire_valid;
	cpu_isa_pkg::word_t retire_ins, retire_imm;
	logic [ADDRESS_BITS - 1:0] retire_pc;

	// Program table with the expected number of retired words
	cpu_isa_pkg::word_t prog_mem [0:NUM_PROGS - 1][0:MAX_WORDS - 1];
	int prog_len [0:NUM_PROGS - 1];
	int exp_count [0:NUM_PROGS - 1];

	cpu_isa_pkg::word_t exp_ins [$], exp_imm [$], got_ins [$], got_imm [$];
	int exp_pc [$], got_pc [$];

	logic [31:0] lfsr_state = 32'h12f5696d;
	logic collecting = 1'b0;
	logic table_ready = 1'b0;
	int watchdog_cycles = 0;

	always #5 CLK = ~CLK;

	slurm16_frontend #(.ADDRESS_BITS(ADDRESS_BITS)) u_slurm16_frontend (
		.CLK(CLK), .RSTb(RSTb), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.retire_valid(retire_valid), .retire_ins(retire_ins), .retire_pc(retire_pc),
		.retire_imm(retire_imm)
	);

	// One retire event per valid cycle, taken mid-cycle
	always @(negedge CLK) begin
		if (collecting && retire_valid) begin
			got_ins.push_back(retire_ins);
			got_pc.push_back(int'(retire_pc));
			got_imm.push_back(retire_imm);
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("FAIL at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
			$display("tests failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("tests failed");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
	endfunction

	function automatic int take_bits(input int n);
		int value;
		value = 0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
		return value;
	endfunction

	task automatic apb_write(input cpu_bus_pkg::apb_addr_t addr, input logic [31:0] data,
		output logic err);
		@(negedge CLK);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge CLK);
		penable = 1'b1;
		@(posedge CLK);
		check_value("pready", pready, 32'h1);
		err = pslverr;   // Transfer completes on this edge
		@(negedge CLK);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input cpu_bus_pkg::apb_addr_t addr, output logic [31:0] data,
		output logic err);
		@(negedge CLK);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge CLK);
		penable = 1'b1;
		@(posedge CLK);
		check_value("pready", pready, 32'h1);
		data = prdata;
		err = pslverr;
		@(negedge CLK);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic add_word(input int p, input cpu_isa_pkg::word_t w);
		prog_mem[p][prog_len[p]] = w;
		prog_len[p]++;
	endtask

	task automatic build_table();
		int dst, src;
		for (int p = 0; p < NUM_PROGS; p++) begin
			prog_len[p] = 0;
			for (int i = 0; i < MAX_WORDS; i++)
				prog_mem[p][i] = cpu_isa_pkg::NOP_INSTRUCTION;
		end
		// Independent ALU words with no register shared within three slots
		add_word(0, 16'h2012);
		add_word(0, 16'h2034);
		add_word(0, 16'h2056);
		add_word(0, 16'h2078);
		add_word(0, 16'h209a);
		add_word(0, 16'h20bc);
		add_word(0, 16'h20de);
		add_word(0, 16'hf000);
		exp_count[0] = 8;
		// IMM prefixes and a branch whose target comes through a prefix
		add_word(1, 16'h1abc);
		add_word(1, 16'h2013);
		add_word(1, 16'h2045);
		add_word(1, 16'h1001);
		add_word(1, 16'h4000);   // Target 0x10
		add_word(1, 16'h2067);
		add_word(1, 16'h2089);
		for (int i = 7; i < 16; i++)
			add_word(1, cpu_isa_pkg::NOP_INSTRUCTION);
		add_word(1, 16'h20ab);
		add_word(1, 16'hf000);
		exp_count[1] = 7;
		// Random ALU words over r0..r3 for dense read-after-write hazards
		for (int k = 0; k < HAZARD_ALU_WORDS; k++) begin
			dst = take_bits(2);
			src = take_bits(2);
			add_word(2, 16'h2000 | 16'(dst << 4) | 16'(src));
		end
		add_word(2, 16'hf000);
		exp_count[2] = HAZARD_ALU_WORDS + 1;
		// Branch over the next two words
		add_word(3, 16'h2012);
		add_word(3, 16'h4004);
		add_word(3, 16'h2034);
		add_word(3, 16'h2056);
		add_word(3, 16'h209a);
		add_word(3, 16'hf000);
		exp_count[3] = 4;
	endtask

	// Reference model walks the program in order, follows branches and skips NOPs
	task automatic build_expected(input int p);
		int pc, steps;
		logic done;
		cpu_isa_pkg::word_t w, imm;
		cpu_isa_pkg::imm_hi_t prefix;
		exp_ins.delete();
		exp_pc.delete();
		exp_imm.delete();
		pc = 0;
		steps = 0;
		prefix = '0;
		done = 1'b0;
		while (!done) begin
			if (pc >= MAX_WORDS || steps > 4 * MAX_WORDS) begin
				abort_run("reference model ran outside the program");
			end else begin
				w = prog_mem[p][pc];
				steps++;
				if (w == cpu_isa_pkg::NOP_INSTRUCTION)
					pc++;
				else begin
					imm = {prefix, w[3:0]};
					exp_ins.push_back(w);
					exp_pc.push_back(pc);
					exp_imm.push_back(imm);
					prefix = (w[15:12] == cpu_isa_pkg::OP_IMM) ? w[11:0] : '0;
					if (w[15:12] == cpu_isa_pkg::OP_HALT)
						done = 1'b1;
					else if (w[15:12] == cpu_isa_pkg::OP_BR)
						pc = int'(imm[ADDRESS_BITS - 1:0]);
					else
						pc++;
				end
			end
		end
	endtask

	initial begin
		wait (table_ready);
		repeat (watchdog_cycles) @(posedge CLK);
		$display("watchdog expired after %0d cycles, the core never finished", watchdog_cycles);
		$display("tests failed");
		$fatal(1, "timeout");
	end

	initial begin
		logic err;
		logic [31:0] rd;
		int polls, total;
		RSTb = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		build_table();
		total = 0;
		for (int p = 0; p < NUM_PROGS; p++)
			total += prog_len[p];
		watchdog_cycles = 200 * total;
		table_ready = 1'b1;
		repeat (8) @(negedge CLK);
		RSTb = 1'b1;

		apb_read(cpu_bus_pkg::REG_STATUS, rd, err);
		check_value("STATUS after reset", rd, 32'h0);
		check_value("pslverr on STATUS read", err, 32'h0);

		for (int p = 0; p < NUM_PROGS; p++) begin
			build_expected(p);
			check_value("model retire count", exp_ins.size(), exp_count[p]);
			for (int i = 0; i < prog_len[p] + PAD_WORDS; i++) begin
				apb_write(cpu_bus_pkg::PROG_BASE + cpu_bus_pkg::apb_addr_t'(4 * i),
					{16'h0, prog_mem[p][i]}, err);
				check_value("pslverr on program write", err, 32'h0);
			end
			got_ins.delete();
			got_pc.delete();
			got_imm.delete();
			collecting = 1'b1;
			apb_write(cpu_bus_pkg::REG_CTRL, 32'h1, err);
			check_value("pslverr on run write", err, 32'h0);
			if (p == 0) begin
				apb_write(cpu_bus_pkg::PROG_BASE + 12'h320, 32'h0, err);   // Word 200
				check_value("pslverr on program write while running", err, 32'h1);
			end
			polls = 0;
			apb_read(cpu_bus_pkg::REG_STATUS, rd, err);
			while (!rd[cpu_bus_pkg::STATUS_HALTED_BIT] && polls < 100 * prog_len[p]) begin
				apb_read(cpu_bus_pkg::REG_STATUS, rd, err);
				polls++;
			end
			collecting = 1'b0;
			if (!rd[cpu_bus_pkg::STATUS_HALTED_BIT]) begin
				abort_run($sformatf("program %0d never reported halted", p));
			end else begin
				check_value("STATUS running bit", rd[cpu_bus_pkg::STATUS_RUN_BIT], 32'h0);
				apb_read(cpu_bus_pkg::REG_RETIRED, rd, err);
				check_value("REG_RETIRED", rd, exp_ins.size());
				check_value("retire event count", got_ins.size(), exp_ins.size());
				for (int i = 0; i < exp_ins.size(); i++) begin
					check_value($sformatf("retire_ins[%0d]", i), got_ins[i], exp_ins[i]);
					check_value($sformatf("retire_pc[%0d]", i), got_pc[i], exp_pc[i]);
					check_value($sformatf("retire_imm[%0d]", i), got_imm[i], exp_imm[i]);
				end
			end
		end

		// Hole in the map between the registers and the program window
		apb_read(12'h010, rd, err);
		check_value("pslverr on unmapped read", err, 32'h1);

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== sim.f ====
cpu_isa_pkg.sv
cpu_bus_pkg.sv
instruction_memory.sv
prog_apb_port.sv
fetch_sequencer.sv
stall_mask_timer.sv
hazard_unit.sv
cpu_pipeline.sv
slurm16_frontend.sv
tb_frontend.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_frontend
FILELIST  = sim.f
PASS_TEXT = all tests passed

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
